// File: hw/x86_arch_pkg.sv
/*
 * Architectural constants for the 32-bit general registers.
 * Sized writes touch only the low byte or word and keep the upper bits.
 */
package x86_arch_pkg;

    localparam int NUM_GPRS = 8;

    typedef logic [2:0]  reg_num_t;
    typedef logic [31:0] data_word_t;

    localparam reg_num_t REG_ESP = 3'd4;
    localparam reg_num_t REG_ESI = 3'd6;
    localparam reg_num_t REG_EDI = 3'd7;

    typedef enum logic [1:0] {
        SZ_NONE  = 2'd0,
        SZ_BYTE  = 2'd1,
        SZ_WORD  = 2'd2,
        SZ_DWORD = 2'd3
    } op_size_t;

    // Kinds other than these two carry no register
    typedef enum logic [2:0] {
        OPND_NONE      = 3'd0,
        OPND_DEC_REG   = 3'd1,
        OPND_MODRM_REG = 3'd4
    } opnd_kind_t;

    // Jumps do not write op0
    localparam logic [3:0] ALU_JMP = 4'd6;

    // Sized write into an existing register value
    function automatic data_word_t sized_merge(data_word_t old_val, data_word_t new_val,
                                               op_size_t size);
        data_word_t merged;
        merged = old_val;
        case (size)
            SZ_BYTE:  merged[7:0] = new_val[7:0];
            SZ_WORD:  merged[15:0] = new_val[15:0];
            SZ_DWORD: merged = new_val;
            default:  merged = old_val;
        endcase
        return merged;
    endfunction

    // Step an address by the operand size in bytes
    function automatic data_word_t step_addr(data_word_t value, op_size_t size, logic down);
        data_word_t delta;
        case (size)
            SZ_BYTE:  delta = 32'd1;
            SZ_WORD:  delta = 32'd2;
            SZ_DWORD: delta = 32'd4;
            default:  delta = 32'd0;
        endcase
        return down ? value - delta : value + delta;
    endfunction

endpackage

// File: hw/ra_pipe_pkg.sv
/*
 * Bundles exchanged by the register access stage.
 * Only the fields this stage reads or produces are carried.
 */
package ra_pipe_pkg;

    import x86_arch_pkg::*;

    // Decoded instruction from the decoder
    typedef struct packed {
        op_size_t   size;
        opnd_kind_t op0_kind;
        opnd_kind_t op1_kind;
        reg_num_t   op0_reg;
        reg_num_t   op1_reg;
        logic [7:0] modrm;
        logic [3:0] alu_op;
        logic       stack_pop;
        logic       stack_push;
        logic       movs;
        logic       set_df;
        logic       clr_df;
    } decode_bundle_t;

    // Register writeback
    typedef struct packed {
        logic       en;
        reg_num_t   reg_num;
        op_size_t   size;
        data_word_t data;
    } wb_bundle_t;

    // Toward address generation
    typedef struct packed {
        op_size_t   size;
        logic [3:0] alu_op;
        reg_num_t   op0_reg;
        reg_num_t   op1_reg;
        data_word_t op0_val;
        data_word_t op1_val;
        data_word_t stack_addr;
        // ESI and EDI after any MOVS step
        data_word_t esi;
        data_word_t edi;
        logic       stack_pop;
        logic       stack_push;
    } ra_out_bundle_t;

endpackage

// File: hw/gpr_file.sv
/*
 * Eight 32-bit general registers, one sized writeback port.
 * ESI/EDI outputs already include the MOVS step while str_step is high.
 * A writeback of ESI or EDI wins over a step in the same cycle.
 */
module gpr_file
    import x86_arch_pkg::*, ra_pipe_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  wb_bundle_t wb,
    input  reg_num_t   rd_a,
    input  reg_num_t   rd_b,
    output data_word_t rd_a_data,
    output data_word_t rd_b_data,
    output data_word_t esp,
    output data_word_t esi,
    output data_word_t edi,
    input  logic       str_step,
    input  op_size_t   str_size,
    input  logic       flag_df
);

    data_word_t gpr [NUM_GPRS];
    data_word_t esi_next;
    data_word_t edi_next;

    // Downward when the direction flag is set
    assign esi_next = step_addr(gpr[REG_ESI], str_size, flag_df);
    assign edi_next = step_addr(gpr[REG_EDI], str_size, flag_df);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_GPRS; i++) begin
                gpr[i] <= '0;
            end
        end else begin
            if (str_step) begin
                gpr[REG_ESI] <= esi_next;
                gpr[REG_EDI] <= edi_next;
            end
            // Later assignment, so writeback takes priority
            if (wb.en) begin
                gpr[wb.reg_num] <= sized_merge(gpr[wb.reg_num], wb.data, wb.size);
            end
        end
    end

    // Combinational reads
    assign rd_a_data = gpr[rd_a];
    assign rd_b_data = gpr[rd_b];
    assign esp = gpr[REG_ESP];

    assign esi = str_step ? esi_next : gpr[REG_ESI];
    assign edi = str_step ? edi_next : gpr[REG_EDI];

    // String pointers must not be written back while a MOVS is accepted
    a_no_step_wb_clash: assert property (
        @(posedge clk) disable iff (!arst_n)
        str_step |-> !(wb.en && (wb.reg_num == REG_ESI || wb.reg_num == REG_EDI))
    );

endmodule

// File: hw/gpr_scoreboard.sv
/*
 * One pending bit per register for writes still in flight.
 * Set and clear land at the clock edge, hazard is combinational.
 * The caller qualifies set_en and the used bits.
 */
module gpr_scoreboard
    import x86_arch_pkg::*, ra_pipe_pkg::*;
#(
    parameter int NUM_REGS = 8
) (
    input  logic       clk,
    input  logic       arst_n,
    input  reg_num_t   src_a,
    input  logic       src_a_used,
    input  reg_num_t   src_b,
    input  logic       src_b_used,
    input  reg_num_t   dst,
    input  logic       set_en,
    input  wb_bundle_t clr,
    output logic       hazard
);

    logic [NUM_REGS-1:0] pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else begin
            if (clr.en) begin
                pending[clr.reg_num] <= 1'b0;
            end
            if (set_en) begin
                pending[dst] <= 1'b1;
            end
        end
    end

    // Any used source still waiting on writeback
    always_comb begin
        hazard = 1'b0;
        if (src_a_used && pending[src_a]) begin
            hazard = 1'b1;
        end
        if (src_b_used && pending[src_b]) begin
            hazard = 1'b1;
        end
    end

    // Op0 is also a source, so a new writer waits for the old writeback
    a_no_set_clr_same_reg: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(set_en && clr.en && dst == clr.reg_num)
    );

endmodule

// File: hw/stack_pointer_tracker.sv
/*
 * Speculative working ESP for push and pop, loaded by ESP writeback.
 * Stack addresses are flat; the SS base is taken as zero.
 * A stack operation stalls in the cycle that ESP is written back.
 */
module stack_pointer_tracker
    import x86_arch_pkg::*, ra_pipe_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       accept,
    input  logic       pop,
    input  logic       push,
    input  op_size_t   size,
    input  wb_bundle_t wb,
    output data_word_t stack_addr,
    output logic       esp_stall
);

    data_word_t work_esp;
    data_word_t esp_down;
    data_word_t esp_up;
    logic       wb_esp;

    assign wb_esp = wb.en && (wb.reg_num == REG_ESP);

    assign esp_down = step_addr(work_esp, size, 1'b1);
    assign esp_up = step_addr(work_esp, size, 1'b0);

    // Push uses the decremented value, pop the current one
    assign stack_addr = push ? esp_down : work_esp;

    assign esp_stall = (pop || push) && wb_esp;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            work_esp <= '0;
        end else if (wb_esp) begin
            work_esp <= sized_merge(work_esp, wb.data, wb.size);
        end else if (accept && push) begin
            work_esp <= esp_down;
        end else if (accept && pop) begin
            work_esp <= esp_up;
        end
    end

    a_stack_op_not_byte: assert property (
        @(posedge clk) disable iff (!arst_n)
        accept && (pop || push) |-> size != SZ_BYTE
    );

endmodule

// File: hw/ra_output_stage.sv
/*
 * One-entry valid/ready register toward address generation.
 * Accepts a new entry in the same cycle the held one leaves.
 */
module ra_output_stage
    import ra_pipe_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           in_valid,
    output logic           in_ready,
    input  ra_out_bundle_t in_bundle,
    output logic           out_valid,
    input  logic           out_ready,
    output ra_out_bundle_t out_bundle
);

    logic load;

    assign in_ready = !out_valid || out_ready;
    assign load = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (load) begin
            out_bundle <= in_bundle;
        end
    end

    // Held entry must not change under back-pressure
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_bundle)
    );

endmodule

// File: hw/register_access_top.sv
/*
 * Register access stage: operand lookup, hazard stall, stack and MOVS pointers.
 * One instruction per handshake; results appear one cycle after acceptance.
 * No flush; the architectural ESP changes only through writeback.
 */
module register_access_top
    import x86_arch_pkg::*, ra_pipe_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           d_valid,
    output logic           d_ready,
    input  decode_bundle_t d_bundle,
    output logic           r_valid,
    input  logic           r_ready,
    output ra_out_bundle_t r_bundle,
    input  wb_bundle_t     wb,
    input  logic           flag_df
);

    reg_num_t       op0_reg;
    reg_num_t       op1_reg;
    logic           op0_used;
    logic           op1_used;
    data_word_t     rd_a_data;
    data_word_t     rd_b_data;
    data_word_t     gpr_esi;
    data_word_t     gpr_edi;
    data_word_t     stack_addr;
    logic           hazard;
    logic           esp_stall;
    logic           room;
    logic           accept;
    logic           set_en;
    logic           str_step;
    ra_out_bundle_t stage_bundle;

    // Kind 4 takes the register from modrm r/m
    assign op0_reg = (d_bundle.op0_kind == OPND_MODRM_REG) ? d_bundle.modrm[2:0]
                                                           : d_bundle.op0_reg;
    assign op1_reg = (d_bundle.op1_kind == OPND_MODRM_REG) ? d_bundle.modrm[2:0]
                                                           : d_bundle.op1_reg;

    assign op0_used = (d_bundle.op0_kind == OPND_MODRM_REG)
                   || (d_bundle.op0_kind == OPND_DEC_REG);
    assign op1_used = (d_bundle.op1_kind == OPND_MODRM_REG)
                   || (d_bundle.op1_kind == OPND_DEC_REG);

    // Hold off while stalled, only when something is offered
    assign d_ready = room && (!d_valid || !(hazard || esp_stall));
    assign accept = d_valid && d_ready;

    assign set_en = accept && op0_used && (d_bundle.alu_op != ALU_JMP);
    assign str_step = accept && d_bundle.movs;

    gpr_file u_gpr_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb        (wb),
        .rd_a      (op0_reg),
        .rd_b      (op1_reg),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data),
        .esp       (),
        .esi       (gpr_esi),
        .edi       (gpr_edi),
        .str_step  (str_step),
        .str_size  (d_bundle.size),
        .flag_df   (flag_df)
    );

    gpr_scoreboard #(
        .NUM_REGS (NUM_GPRS)
    ) u_gpr_scoreboard (
        .clk        (clk),
        .arst_n     (arst_n),
        .src_a      (op0_reg),
        .src_a_used (op0_used),
        .src_b      (op1_reg),
        .src_b_used (op1_used),
        .dst        (op0_reg),
        .set_en     (set_en),
        .clr        (wb),
        .hazard     (hazard)
    );

    stack_pointer_tracker u_stack_pointer_tracker (
        .clk        (clk),
        .arst_n     (arst_n),
        .accept     (accept),
        .pop        (d_bundle.stack_pop),
        .push       (d_bundle.stack_push),
        .size       (d_bundle.size),
        .wb         (wb),
        .stack_addr (stack_addr),
        .esp_stall  (esp_stall)
    );

    always_comb begin
        stage_bundle.size       = d_bundle.size;
        stage_bundle.alu_op     = d_bundle.alu_op;
        stage_bundle.op0_reg    = op0_reg;
        stage_bundle.op1_reg    = op1_reg;
        stage_bundle.op0_val    = rd_a_data;
        stage_bundle.op1_val    = rd_b_data;
        stage_bundle.stack_addr = stack_addr;
        stage_bundle.esi        = gpr_esi;
        stage_bundle.edi        = gpr_edi;
        stage_bundle.stack_pop  = d_bundle.stack_pop;
        stage_bundle.stack_push = d_bundle.stack_push;
    end

    ra_output_stage u_ra_output_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (accept),
        .in_ready   (room),
        .in_bundle  (stage_bundle),
        .out_valid  (r_valid),
        .out_ready  (r_ready),
        .out_bundle (r_bundle)
    );

endmodule

// File: tb/ra_checker.sv
/*
 * Compares each output transfer with the next I line of tb/ra_golden.txt, in order.
 * Also fails any accept that lands inside a stall window declared by the driver.
 */
module ra_checker
    import x86_arch_pkg::*, ra_pipe_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           d_valid,
    input  logic           d_ready,
    input  logic           stall_window,
    input  logic           r_valid,
    input  logic           r_ready,
    input  ra_out_bundle_t r_bundle,
    output logic           all_seen,
    output int             pass_count,
    output int             fail_count
);

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [1:0] size;
        logic [3:0] alu_op;
        reg_num_t   op0_reg;
        reg_num_t   op1_reg;
        logic       stack_pop;
        logic       stack_push;
        data_word_t op0_val;
        data_word_t op1_val;
        data_word_t stack_addr;
        data_word_t esi;
        data_word_t edi;
    } expect_t;

    string   names[$];
    expect_t expects[$];
    int      seen;

    // Modrm r/m for kind 4, decoder register otherwise
    function automatic reg_num_t resolve_operand_reg(int kind, int dec_reg, logic [7:0] modrm);
        return (kind == 4) ? modrm[2:0] : reg_num_t'(dec_reg);
    endfunction

    initial begin
        int         fd;
        int         n;
        int         k0, r0, k1, r1, alu, sz, pop, push;
        logic [7:0] modrm;
        string      line;
        string      name;
        expect_t    exp_line;
        seen = 0;
        pass_count = 0;
        fail_count = 0;
        fd = $fopen("tb/ra_golden.txt", "r");
        if (fd == 0) begin
            $display("Checker cannot open tb/ra_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) == "I") begin
                    // Movs, df, stall and rr only steer the driver
                    n = $sscanf(line,
                        "I %s %d %d %d %d %h %d %d %d %d %*d %*d %*d %*d %h %h %h %h %h",
                        name, k0, r0, k1, r1, modrm, alu, sz, pop, push,
                        exp_line.op0_val, exp_line.op1_val, exp_line.stack_addr,
                        exp_line.esi, exp_line.edi);
                    if (n != 15) begin
                        $display("Checker found a malformed instruction line: %s", line);
                        fail_count++;
                    end else begin
                        exp_line.size = sz[1:0];
                        exp_line.alu_op = alu[3:0];
                        exp_line.op0_reg = resolve_operand_reg(k0, r0, modrm);
                        exp_line.op1_reg = resolve_operand_reg(k1, r1, modrm);
                        exp_line.stack_pop = pop[0];
                        exp_line.stack_push = push[0];
                        names.push_back(name);
                        expects.push_back(exp_line);
                    end
                end
            end
            $fclose(fd);
        end
        all_seen = (names.size() == 0);
    end

    task automatic check_field(string name, string field, data_word_t exp_val,
                               data_word_t act_val, inout int bad);
        if (exp_val !== act_val) begin
            $display("[ERROR] %s %s expected %08h actual %08h", name, field, exp_val, act_val);
            bad++;
        end
    endtask

    task automatic compare_output(string name, expect_t exp_line);
        int bad;
        bad = 0;
        check_field(name, "size", data_word_t'(exp_line.size),
                    data_word_t'(r_bundle.size), bad);
        check_field(name, "alu_op", data_word_t'(exp_line.alu_op),
                    data_word_t'(r_bundle.alu_op), bad);
        check_field(name, "op0_reg", data_word_t'(exp_line.op0_reg),
                    data_word_t'(r_bundle.op0_reg), bad);
        check_field(name, "op1_reg", data_word_t'(exp_line.op1_reg),
                    data_word_t'(r_bundle.op1_reg), bad);
        check_field(name, "stack_pop", data_word_t'(exp_line.stack_pop),
                    data_word_t'(r_bundle.stack_pop), bad);
        check_field(name, "stack_push", data_word_t'(exp_line.stack_push),
                    data_word_t'(r_bundle.stack_push), bad);
        check_field(name, "op0", exp_line.op0_val, r_bundle.op0_val, bad);
        check_field(name, "op1", exp_line.op1_val, r_bundle.op1_val, bad);
        check_field(name, "stack_addr", exp_line.stack_addr, r_bundle.stack_addr, bad);
        check_field(name, "esi", exp_line.esi, r_bundle.esi, bad);
        check_field(name, "edi", exp_line.edi, r_bundle.edi, bad);
        if (bad == 0) begin
            pass_count++;
            $display("[PASS] %s", name);
        end else begin
            fail_count++;
            $display("[FAIL] %s", name);
        end
    endtask

    always @(posedge clk) begin
        if (arst_n && stall_window && d_valid && d_ready) begin
            $display("Instruction accepted while its source register was pending, at %0t", $time);
            fail_count++;
        end
        if (arst_n && r_valid && r_ready) begin
            if (seen >= names.size()) begin
                $display("Output transfer with no expected instruction left, at %0t", $time);
                fail_count++;
            end else begin
                compare_output(names[seen], expects[seen]);
            end
            seen++;
            all_seen = (seen >= names.size());
        end
    end

endmodule

// File: tb/tb_register_access.sv
/*
 * Testbench for the register access stage, stimulus from tb/ra_golden.txt.
 * Run from the project root. An I line with a stall count is held until
 * the W line after it has been applied.
 */
module tb_register_access
    import x86_arch_pkg::*, ra_pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam logic [31:0] SEED = 32'hd717_1256;

    logic           clk;
    logic           arst_n;
    logic           d_valid;
    logic           d_ready;
    decode_bundle_t d_bundle;
    logic           r_valid;
    logic           r_ready;
    ra_out_bundle_t r_bundle;
    wb_bundle_t     wb;
    logic           flag_df;
    logic           stall_window;
    logic           rr_random = 1'b0;
    logic           run_broken;
    logic           all_seen;
    int             pass_count;
    int             fail_count;

    register_access_top u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .d_valid  (d_valid),
        .d_ready  (d_ready),
        .d_bundle (d_bundle),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_bundle (r_bundle),
        .wb       (wb),
        .flag_df  (flag_df)
    );

    ra_checker u_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .d_valid      (d_valid),
        .d_ready      (d_ready),
        .stall_window (stall_window),
        .r_valid      (r_valid),
        .r_ready      (r_ready),
        .r_bundle     (r_bundle),
        .all_seen     (all_seen),
        .pass_count   (pass_count),
        .fail_count   (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Back-pressure only while the current I line asks for it
    initial begin
        void'($urandom(SEED));
        r_ready = 1'b1;
        forever begin
            @(negedge clk);
            r_ready = rr_random ? ($urandom % 2 == 1) : 1'b1;
        end
    end

    task automatic wait_accept();
        int cycles;
        bit taken;
        cycles = 0;
        taken = 0;
        while (!taken && !run_broken) begin
            @(posedge clk);
            if (d_ready) begin
                taken = 1;
            end else if (cycles == TIMEOUT_CYCLES) begin
                run_broken = 1'b1;
                $display("Timeout: instruction not accepted within %0d cycles", TIMEOUT_CYCLES);
            end
            cycles++;
        end
        @(negedge clk);
        d_valid = 1'b0;
    endtask

    task automatic apply_writeback(int reg_idx, int size, data_word_t data);
        wb.en = 1'b1;
        wb.reg_num = reg_num_t'(reg_idx);
        wb.size = op_size_t'(size);
        wb.data = data;
        @(negedge clk);
        wb = '0;
    endtask

    task automatic play_golden(int fd);
        string      line;
        string      name;
        int         n;
        int         k0, r0, k1, r1, alu, sz, pop, push, movs, df, stall, rr;
        logic [7:0] modrm;
        data_word_t wdata;
        bit         held;
        held = 0;
        while (!$feof(fd) && !run_broken) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) == "W") begin
                n = $sscanf(line, "W %d %d %h", r0, sz, wdata);
                apply_writeback(r0, sz, wdata);
                if (held) begin
                    held = 0;
                    wait_accept();
                end
            end else if (n > 0 && line.getc(0) == "I") begin
                n = $sscanf(line, "I %s %d %d %d %d %h %d %d %d %d %d %d %d %d", name,
                            k0, r0, k1, r1, modrm, alu, sz, pop, push, movs, df, stall, rr);
                if (n != 14) begin
                    run_broken = 1'b1;
                    $display("Malformed instruction line in golden file: %s", line);
                end else begin
                    d_bundle = '0;
                    d_bundle.size = op_size_t'(sz);
                    d_bundle.op0_kind = opnd_kind_t'(k0);
                    d_bundle.op1_kind = opnd_kind_t'(k1);
                    d_bundle.op0_reg = reg_num_t'(r0);
                    d_bundle.op1_reg = reg_num_t'(r1);
                    d_bundle.modrm = modrm;
                    d_bundle.alu_op = alu[3:0];
                    d_bundle.stack_pop = pop[0];
                    d_bundle.stack_push = push[0];
                    d_bundle.movs = movs[0];
                    flag_df = df[0];
                    rr_random = rr[0];
                    d_valid = 1'b1;
                    if (stall > 0) begin
                        // Must not be taken before the following writeback
                        stall_window = 1'b1;
                        repeat (stall) @(posedge clk);
                        @(negedge clk);
                        stall_window = 1'b0;
                        held = 1;
                    end else begin
                        wait_accept();
                    end
                end
            end
        end
    endtask

    task automatic drain_outputs();
        int cycles;
        cycles = 0;
        while (!all_seen && !run_broken) begin
            @(negedge clk);
            if (cycles == TIMEOUT_CYCLES) begin
                run_broken = 1'b1;
                $display("Timeout: not every expected instruction reached the output");
            end
            cycles++;
        end
    endtask

    initial begin
        int fd;
        arst_n = 1'b0;
        d_valid = 1'b0;
        d_bundle = '0;
        wb = '0;
        flag_df = 1'b0;
        stall_window = 1'b0;
        run_broken = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        fd = $fopen("tb/ra_golden.txt", "r");
        if (fd == 0) begin
            run_broken = 1'b1;
            $display("Cannot open tb/ra_golden.txt");
        end else begin
            play_golden(fd);
            $fclose(fd);
        end
        rr_random = 1'b0;
        drain_outputs();
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (!run_broken && all_seen && fail_count == 0 && pass_count > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb/ra_golden.txt
# W reg size data   (size 1 byte, 2 word, 3 dword)
# I name k0 r0 k1 r1 modrm alu size pop push movs df stall rr op0 op1 stack esi edi
W 0 3 11223344
W 1 3 55667788
W 2 3 99aabbcc
W 3 3 0badf00d
W 4 3 00001000
W 5 3 cafe0005
W 6 3 00002000
W 7 3 00003000
W 0 1 000000ee
W 1 2 0000abcd
I rm_dec 4 0 1 2 c3 6 3 0 0 0 0 0 0 0badf00d 99aabbcc 00001000 00002000 00003000
I dec_rm 1 1 4 0 c5 6 3 0 0 0 0 0 0 5566abcd cafe0005 00001000 00002000 00003000
I sized 1 0 1 1 00 6 3 0 0 0 0 0 0 112233ee 5566abcd 00001000 00002000 00003000
I no_kind 0 2 0 5 00 6 3 0 0 0 0 0 0 99aabbcc cafe0005 00001000 00002000 00003000
I wr_eax 1 0 1 2 00 0 3 0 0 0 0 0 0 112233ee 99aabbcc 00001000 00002000 00003000
I rd_eax 1 3 1 0 00 0 3 0 0 0 0 4 0 0badf00d 12345678 00001000 00002000 00003000
W 0 3 12345678
W 3 3 bbbb0003
I jmp_ecx 1 1 0 0 00 6 3 0 0 0 0 0 0 5566abcd 12345678 00001000 00002000 00003000
I rd_ecx 1 2 1 1 00 6 3 0 0 0 0 0 0 99aabbcc 5566abcd 00001000 00002000 00003000
W 4 3 00008000
I push_d 0 0 0 0 00 0 3 0 1 0 0 0 0 12345678 12345678 00007ffc 00002000 00003000
I push_w 0 0 0 0 00 0 2 0 1 0 0 0 0 12345678 12345678 00007ffa 00002000 00003000
I pop_w 0 0 0 0 00 0 2 1 0 0 0 0 0 12345678 12345678 00007ffa 00002000 00003000
I pop_d 0 0 0 0 00 0 3 1 0 0 0 0 0 12345678 12345678 00007ffc 00002000 00003000
I pop_d2 0 0 0 0 00 0 3 1 0 0 0 0 0 12345678 12345678 00008000 00002000 00003000
I movsb_up 0 0 0 0 00 0 1 0 0 1 0 0 0 12345678 12345678 00008004 00002001 00003001
I movsw_up 0 0 0 0 00 0 2 0 0 1 0 0 0 12345678 12345678 00008004 00002003 00003003
I movsd_up 0 0 0 0 00 0 3 0 0 1 0 0 0 12345678 12345678 00008004 00002007 00003007
I movsb_dn 0 0 0 0 00 0 1 0 0 1 1 0 0 12345678 12345678 00008004 00002006 00003006
I movsw_dn 0 0 0 0 00 0 2 0 0 1 1 0 0 12345678 12345678 00008004 00002004 00003004
I movsd_dn 0 0 0 0 00 0 3 0 0 1 1 0 0 12345678 12345678 00008004 00002000 00003000
I bp_a 1 0 1 1 00 6 3 0 0 0 0 0 1 12345678 5566abcd 00008004 00002000 00003000
I bp_b 1 2 1 3 00 6 3 0 0 0 0 0 1 99aabbcc bbbb0003 00008004 00002000 00003000
I bp_c 4 0 1 4 c5 6 3 0 0 0 0 0 1 cafe0005 00008000 00008004 00002000 00003000
I bp_d 1 6 1 7 00 6 3 0 0 0 0 0 1 00002000 00003000 00008004 00002000 00003000
I bp_e 0 5 0 5 00 0 3 0 1 0 0 0 1 cafe0005 cafe0005 00008000 00002000 00003000
I bp_f 0 1 0 2 00 0 3 0 0 1 0 0 1 5566abcd 99aabbcc 00008000 00002004 00003004

// File: sim.f
hw/x86_arch_pkg.sv
hw/ra_pipe_pkg.sv
hw/gpr_file.sv
hw/gpr_scoreboard.sv
hw/stack_pointer_tracker.sv
hw/ra_output_stage.sv
hw/register_access_top.sv
tb/ra_checker.sv
tb/tb_register_access.sv
